/* source/aluPkg.sv */
// ------------------------------
// ALU shared definitions.
// Widths, opcode values, error flag positions
// and the two-way opcode view.
// ------------------------------
package aluPkg;

	// ------------------------------
	// Widths
	// ------------------------------

	// Each operand is one 16-bit word.
	localparam int operandWidth = 16;
	// Full result word, wide enough for the product.
	localparam int resultWidth = 32;
	localparam int errorWidth = 2;
	localparam int opcodeWidth = 4;

	// Error flag positions.
	localparam int divZeroBit = 1;
	localparam int overflowBit = 0;

	// ------------------------------
	// Opcode values
	// ------------------------------

	// Add and subtract differ only in the low bit.
	localparam logic [opcodeWidth-1:0] opAdd = 4'b1010;
	localparam logic [opcodeWidth-1:0] opSub = 4'b1011;
	localparam logic [opcodeWidth-1:0] opMul = 4'b0010;
	localparam logic [opcodeWidth-1:0] opDiv = 4'b0011;
	localparam logic [opcodeWidth-1:0] opMod = 4'b0100;

	// Field view of the opcode.
	// Mode set means subtract in the add/subtract group.
	typedef struct packed {
		logic [opcodeWidth-2:0] group;
		logic                   mode;
	} opFieldsT;

	// The same opcode bits, read whole or by field.
	typedef union packed {
		logic [opcodeWidth-1:0] code;
		opFieldsT               fields;
	} opcodeT;

endpackage

/* source/operandRegister.sv */
// ------------------------------
// Operand register stage.
// Captures operands and opcode on start
// and flags the operation in flight.
// ------------------------------
module operandRegister (
	input  logic                             clk,
	input  logic                             rstN,
	input  logic                             start,
	input  logic [aluPkg::operandWidth-1:0]  a,
	input  logic [aluPkg::operandWidth-1:0]  b,
	input  aluPkg::opcodeT                   op,
	output logic [aluPkg::operandWidth-1:0]  aQ,
	output logic [aluPkg::operandWidth-1:0]  bQ,
	output aluPkg::opcodeT                   opQ,
	output logic                             validQ
);

	// ------------------------------
	// Valid flag
	// ------------------------------

	// One cycle per start strobe.
	// Back-to-back strobes keep it high.
	always_ff @(posedge clk)
	begin
		if (!rstN)
			validQ <= 1'b0;
		else
			validQ <= start;
	end

	// ------------------------------
	// Operand hold
	// ------------------------------

	// Loaded only on start, so the units see stable inputs.
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			aQ  <= a;
			bQ  <= b;
			opQ <= op;
		end
	end

endmodule

/* source/addSubUnit.sv */
// ------------------------------
// Add/subtract unit.
// Two's-complement add or subtract with
// overflow folded into the result word.
// ------------------------------
module addSubUnit (
	input  logic [aluPkg::operandWidth-1:0] aQ,
	input  logic [aluPkg::operandWidth-1:0] bQ,
	input  aluPkg::opcodeT                  opQ,
	output logic [aluPkg::resultWidth-1:0]  addSubResult,
	output logic                            overflow
);

	import aluPkg::*;

	// Subtract selected by the opcode mode bit.
	logic                    mode;
	// Second operand, inverted when subtracting.
	logic [operandWidth-1:0] bInv;
	// Low bits with the carry into the top bit.
	logic [operandWidth-1:0] lowSum;
	// Top bit with its carry out.
	logic [1:0]              topSum;
	logic                    carryIn;
	logic                    carryOut;

	assign mode = opQ.fields.mode;
	assign bInv = bQ ^ {operandWidth{mode}};

	// ------------------------------
	// Carry chain
	// ------------------------------

	// Mode doubles as the carry in, giving a + ~b + 1.
	assign lowSum  = {1'b0, aQ[operandWidth-2:0]} + {1'b0, bInv[operandWidth-2:0]} +
		{{(operandWidth-1){1'b0}}, mode};
	assign carryIn = lowSum[operandWidth-1];

	// Top bit split off to expose both carries.
	assign topSum   = {1'b0, aQ[operandWidth-1]} + {1'b0, bInv[operandWidth-1]} +
		{1'b0, carryIn};
	assign carryOut = topSum[1];

	// Unsigned carry when adding, signed overflow when subtracting.
	assign overflow = mode ? (carryIn ^ carryOut) : carryOut;

	// Sum in the low half, overflow repeated above it.
	assign addSubResult = {{(resultWidth-operandWidth-1){1'b0}}, overflow,
		topSum[0], lowSum[operandWidth-2:0]};

endmodule

/* source/multiplierArray.sv */
// ------------------------------
// Array multiplier.
// Unsigned 16x16 product built from one
// shift-and-add row per multiplier bit.
// ------------------------------
module multiplierArray (
	input  logic [aluPkg::operandWidth-1:0] aQ,
	input  logic [aluPkg::operandWidth-1:0] bQ,
	output logic [aluPkg::resultWidth-1:0]  product
);

	import aluPkg::*;

	// ------------------------------
	// Row array
	// ------------------------------

	genvar row;
	generate
		for (row = 0; row < operandWidth; row++)
		begin : genRow
			// Partial product of bQ gated by one bit of aQ.
			logic [operandWidth-1:0] partial;
			// Row sum with its carry in the top bit.
			logic [operandWidth:0]   rowSum;
			// Row sum shifted down, carry on top, fed to the next row.
			logic [operandWidth-1:0] acc;

			assign partial = bQ & {operandWidth{aQ[row]}};

			if (row == 0)
			begin : genFirst
				// First row has nothing to add to.
				assign rowSum = {1'b0, partial};
			end
			else
			begin : genNext
				assign rowSum = {1'b0, genRow[row-1].acc} + {1'b0, partial};
			end

			// Lowest bit of each row is final.
			assign product[row] = rowSum[0];
			assign acc          = rowSum[operandWidth:1];
		end
	endgenerate

	// Last row supplies the upper half, carry included.
	assign product[resultWidth-1:operandWidth] = genRow[operandWidth-1].acc;

endmodule

/* source/divModUnit.sv */
// ------------------------------
// Divide/modulo unit.
// Unsigned quotient and remainder with
// a zero divisor check.
// ------------------------------
module divModUnit (
	input  logic [aluPkg::operandWidth-1:0] aQ,
	input  logic [aluPkg::operandWidth-1:0] bQ,
	output logic [aluPkg::resultWidth-1:0]  quotient,
	output logic [aluPkg::resultWidth-1:0]  remainder,
	output logic                            divZero
);

	import aluPkg::*;

	// Zero-extension of the 16-bit results.
	localparam int padWidth = resultWidth - operandWidth;

	// Shared by divide and modulo.
	assign divZero = (bQ == '0);

	// ------------------------------
	// Quotient and remainder
	// ------------------------------

	// Zero divisor forces a zero result.
	assign quotient  = divZero ? '0 : {{padWidth{1'b0}}, aQ / bQ};
	assign remainder = divZero ? '0 : {{padWidth{1'b0}}, aQ % bQ};

endmodule

/* source/resultSelect.sv */
// ------------------------------
// Result stage.
// Picks the unit result and flags by opcode
// and registers them with the done pulse.
// ------------------------------
module resultSelect (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           validQ,
	input  aluPkg::opcodeT                 opQ,
	input  logic [aluPkg::resultWidth-1:0] addSubResult,
	input  logic                           overflow,
	input  logic [aluPkg::resultWidth-1:0] product,
	input  logic [aluPkg::resultWidth-1:0] quotient,
	input  logic [aluPkg::resultWidth-1:0] remainder,
	input  logic                           divZero,
	output logic [aluPkg::resultWidth-1:0] result,
	output logic [aluPkg::errorWidth-1:0]  error,
	output logic                           done
);

	import aluPkg::*;

	// Selected result and flags ahead of the register.
	logic [resultWidth-1:0] nextResult;
	logic [errorWidth-1:0]  nextError;

	// ------------------------------
	// Opcode decode
	// ------------------------------

	// Flags come only from the unit that is selected.
	always_comb
	begin
		nextResult = '0;
		nextError  = '0;
		case (opQ.code)
			opAdd,
			opSub:
			begin
				nextResult             = addSubResult;
				nextError[overflowBit] = overflow;
			end
			opMul:
			begin
				nextResult = product;
			end
			opDiv:
			begin
				nextResult            = quotient;
				nextError[divZeroBit] = divZero;
			end
			opMod:
			begin
				nextResult            = remainder;
				nextError[divZeroBit] = divZero;
			end
			default:
			begin
				// Unused opcode, zero and no flags.
				nextResult = '0;
				nextError  = '0;
			end
		endcase
	end

	// ------------------------------
	// Output register
	// ------------------------------

	// Result and error hold until the next valid operation.
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			result <= '0;
			error  <= '0;
			done   <= 1'b0;
		end
		else
		begin
			done <= validQ;
			if (validQ)
			begin
				result <= nextResult;
				error  <= nextError;
			end
		end
	end

endmodule

/* source/aluTop.sv */
// ------------------------------
// ALU top level.
// Operand register, arithmetic units and
// result stage, two cycles start to done.
// ------------------------------
module aluTop (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            start,
	input  logic [aluPkg::operandWidth-1:0] a,
	input  logic [aluPkg::operandWidth-1:0] b,
	input  aluPkg::opcodeT                  op,
	output logic                            done,
	output logic [aluPkg::resultWidth-1:0]  result,
	output logic [aluPkg::errorWidth-1:0]   error
);

	import aluPkg::*;

	// Held operands of the operation in flight.
	logic [operandWidth-1:0] aQ;
	logic [operandWidth-1:0] bQ;
	opcodeT                  opQ;
	logic                    validQ;

	// Unit outputs.
	logic [resultWidth-1:0]  addSubResult;
	logic                    overflow;
	logic [resultWidth-1:0]  product;
	logic [resultWidth-1:0]  quotient;
	logic [resultWidth-1:0]  remainder;
	logic                    divZero;

	// ------------------------------
	// First stage
	// ------------------------------

	operandRegister operandRegister_i (
		.clk    (clk),
		.rstN   (rstN),
		.start  (start),
		.a      (a),
		.b      (b),
		.op     (op),
		.aQ     (aQ),
		.bQ     (bQ),
		.opQ    (opQ),
		.validQ (validQ)
	);

	// Arithmetic units, all combinational.
	addSubUnit addSubUnit_i (
		.aQ           (aQ),
		.bQ           (bQ),
		.opQ          (opQ),
		.addSubResult (addSubResult),
		.overflow     (overflow)
	);

	multiplierArray multiplierArray_i (
		.aQ      (aQ),
		.bQ      (bQ),
		.product (product)
	);

	divModUnit divModUnit_i (
		.aQ        (aQ),
		.bQ        (bQ),
		.quotient  (quotient),
		.remainder (remainder),
		.divZero   (divZero)
	);

	// ------------------------------
	// Second stage
	// ------------------------------

	resultSelect resultSelect_i (
		.clk          (clk),
		.rstN         (rstN),
		.validQ       (validQ),
		.opQ          (opQ),
		.addSubResult (addSubResult),
		.overflow     (overflow),
		.product      (product),
		.quotient     (quotient),
		.remainder    (remainder),
		.divZero      (divZero),
		.result       (result),
		.error        (error),
		.done         (done)
	);

endmodule

/* dv/clockGen.sv */
// ------------------------------
// Testbench clock and reset.
// 100 ns clock, reset low for 5 cycles.
// ------------------------------
module clockGen (
	output logic clk,
	output logic rstN
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int halfPeriod  = 50;
	localparam int resetCycles = 5;

	// Free-running clock.
	initial
	begin
		clk = 1'b0;
		forever
			#halfPeriod clk = ~clk;
	end

	// Reset released just after an edge, like the other inputs.
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1 rstN = 1'b1;
	end

endmodule

/* dv/aluTb.sv */
// ------------------------------
// ALU testbench.
// Random and corner operations against a
// reference model, plus a back-to-back stream.
// ------------------------------
module aluTb;
	timeunit 1ns;
	timeprecision 100ps;

	import aluPkg::*;

	// ------------------------------
	// Test sizes and limits
	// ------------------------------
	localparam logic [31:0] lfsrSeed = 32'h2d78_688c;
	localparam logic [31:0] lfsrTaps = 32'hA300_0000;
	localparam int numRandom = 40;
	localparam int numUnused = 4;
	localparam int numStream = 20;
	// Random ops, then 7 corners and 11 unused opcodes.
	localparam int totalOps   = 5 * numRandom + 7 + 11 * numUnused + numStream;
	localparam int cycleLimit = totalOps + 100;
	// Opcode mix for the stream, one unused code included.
	localparam logic [opcodeWidth-1:0] streamOps [6] = '{opAdd, opSub, opMul, opDiv, opMod, 4'h0};

	logic                    clk;
	logic                    rstN;
	logic                    start;
	logic [operandWidth-1:0] a;
	logic [operandWidth-1:0] b;
	opcodeT                  op;
	logic                    done;
	logic [resultWidth-1:0]  result;
	logic [errorWidth-1:0]   error;

	logic [31:0] lfsrState = lfsrSeed;
	// Expected {error, result}, and the {op, a, b} behind it.
	logic [errorWidth+resultWidth-1:0]     expQ [$];
	logic [opcodeWidth+2*operandWidth-1:0] stimQ [$];
	// Counters of the compare process and of the main sequence.
	int resultChecks = 0;
	int resultFails  = 0;
	int seqChecks    = 0;
	int seqFails     = 0;
	int cycleCount   = 0;

	clockGen clockGen_i (.clk(clk), .rstN(rstN));

	aluTop dut_i (
		.clk    (clk),
		.rstN   (rstN),
		.start  (start),
		.a      (a),
		.b      (b),
		.op     (op),
		.done   (done),
		.result (result),
		.error  (error)
	);

	// Galois LFSR, one step per bit taken.
	function automatic logic [operandWidth-1:0] randomWord();
		logic [operandWidth-1:0] word;
		word = '0;
		for (int i = 0; i < operandWidth; i++)
		begin
			word      = {word[operandWidth-2:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ lfsrTaps) : (lfsrState >> 1);
		end
		return word;
	endfunction

	// Expected {error, result} from the opcode rules.
	function automatic logic [errorWidth+resultWidth-1:0] referenceOf(
		input logic [opcodeWidth-1:0]  code,
		input logic [operandWidth-1:0] x,
		input logic [operandWidth-1:0] y
	);
		int unsigned            ux;
		int unsigned            uy;
		int                     sx;
		int                     sy;
		longint                 wide;
		logic [resultWidth-1:0] r;
		logic [errorWidth-1:0]  e;
		ux = 32'(x);
		uy = 32'(y);
		sx = int'($signed(x));
		sy = int'($signed(y));
		r  = '0;
		e  = '0;
		case (code)
			opAdd:
			begin
				// Unsigned carry out of bit 15.
				wide           = longint'(ux) + longint'(uy);
				e[overflowBit] = (wide > 64'hFFFF);
				r              = 32'(wide) & 32'hFFFF;
			end
			opSub:
			begin
				// Signed overflow of the difference.
				e[overflowBit] = (sx - sy > 32767) || (sx - sy < -32768);
				r              = (ux - uy) & 32'hFFFF;
			end
			opMul:
			begin
				wide = longint'(ux) * longint'(uy);
				r    = 32'(wide);
			end
			opDiv,
			opMod:
			begin
				if (uy == 0)
					e[divZeroBit] = 1'b1;
				else
					r = (code == opDiv) ? ux / uy : ux % uy;
			end
			default:
			begin
				r = '0;
			end
		endcase
		// Bit 16 repeats the add/subtract overflow.
		if (code == opAdd || code == opSub)
			r[operandWidth] = e[overflowBit];
		return {e, r};
	endfunction

	// ------------------------------
	// Compare process
	// ------------------------------

	// Middle of the cycle, where done and the outputs are settled.
	always @(negedge clk)
	begin
		logic [errorWidth+resultWidth-1:0]     expected;
		logic [opcodeWidth+2*operandWidth-1:0] stim;
		if (rstN && done)
		begin
			if (expQ.size() == 0)
			begin
				$display("Done pulse seen with no operation pending");
				resultFails++;
			end
			else
			begin
				expected     = expQ.pop_front();
				stim         = stimQ.pop_front();
				resultChecks += 2;
				if (result !== expected[resultWidth-1:0])
				begin
					$display("[FAIL] result: got %h, expected %h (op %h a %h b %h)", result,
						expected[resultWidth-1:0], stim[35:32], stim[31:16], stim[15:0]);
					resultFails++;
				end
				if (error !== expected[errorWidth+resultWidth-1:resultWidth])
				begin
					$display("[FAIL] error: got %h, expected %h (op %h a %h b %h)", error,
						expected[errorWidth+resultWidth-1:resultWidth], stim[35:32],
						stim[31:16], stim[15:0]);
					resultFails++;
				end
			end
		end
	end

	// Run limit.
	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("Run timed out after %0d cycles with %0d results pending",
				cycleCount, expQ.size());
			$display("Simulation failed");
			$finish;
		end
	end

	// One operation per call; start stays high for the next one.
	task automatic issueOp(
		input logic [opcodeWidth-1:0]  code,
		input logic [operandWidth-1:0] x,
		input logic [operandWidth-1:0] y
	);
		start   = 1'b1;
		a       = x;
		b       = y;
		op.code = code;
		expQ.push_back(referenceOf(code, x, y));
		stimQ.push_back({code, x, y});
		@(posedge clk);
		#1;
	endtask

	// Drains the pending results, then reports the test.
	task automatic endTest(input string name, input int failsBefore);
		start = 1'b0;
		while (expQ.size() != 0)
			@(posedge clk);
		#1;
		$display("Test %-12s %s", name,
			(resultFails + seqFails == failsBefore) ? "passed" : "failed");
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial
	begin
		int                      failsBefore;
		logic [operandWidth-1:0] x;
		start = 1'b0;
		a     = '0;
		b     = '0;
		op    = '0;
		wait (rstN === 1'b1);
		@(posedge clk);
		#1;

		// Outputs cleared before any start.
		failsBefore = 0;
		seqChecks++;
		if (done !== 1'b0 || result !== '0 || error !== '0)
		begin
			$display("[FAIL] reset: done %h result %h error %h, expected all zero",
				done, result, error);
			seqFails++;
		end
		endTest("reset", failsBefore);

		failsBefore = resultFails + seqFails;
		for (int i = 0; i < numRandom; i++)
		begin
			issueOp(opAdd, randomWord(), randomWord());
			issueOp(opSub, randomWord(), randomWord());
		end
		x = randomWord();
		issueOp(opAdd, 16'hFFFF, 16'h0001);
		issueOp(opSub, 16'h7FFF, 16'hFFFF);
		issueOp(opAdd, x, x);
		issueOp(opSub, x, x);
		endTest("add/sub", failsBefore);

		failsBefore = resultFails + seqFails;
		for (int i = 0; i < numRandom; i++)
			issueOp(opMul, randomWord(), randomWord());
		issueOp(opMul, 16'hFFFF, 16'hFFFF);
		endTest("multiply", failsBefore);

		failsBefore = resultFails + seqFails;
		for (int i = 0; i < numRandom; i++)
		begin
			issueOp(opDiv, randomWord(), randomWord());
			issueOp(opMod, randomWord(), randomWord());
		end
		issueOp(opDiv, randomWord(), 16'h0000);
		issueOp(opMod, randomWord(), 16'h0000);
		endTest("div/mod", failsBefore);

		// Every code outside the five operations.
		failsBefore = resultFails + seqFails;
		for (int c = 0; c < 16; c++)
		begin
			if (4'(c) != opAdd && 4'(c) != opSub && 4'(c) != opMul && 4'(c) != opDiv &&
				4'(c) != opMod)
			begin
				for (int i = 0; i < numUnused; i++)
					issueOp(4'(c), randomWord(), randomWord());
			end
		end
		endTest("unused", failsBefore);

		// Back-to-back stream, done high from the second edge on.
		failsBefore = resultFails + seqFails;
		for (int i = 0; i < numStream + 2; i++)
		begin
			if (i < numStream)
			begin
				issueOp(streamOps[i % 6], randomWord(), randomWord());
			end
			else
			begin
				start = 1'b0;
				@(posedge clk);
				#1;
			end
			seqChecks++;
			if (done !== 1'((i != 0) && (i <= numStream)))
			begin
				$display("[FAIL] done: got %h, expected %h at stream cycle %0d",
					done, 1'((i != 0) && (i <= numStream)), i);
				seqFails++;
			end
		end
		endTest("stream", failsBefore);

		$display("Checks: %0d, failures: %0d", resultChecks + seqChecks,
			resultFails + seqFails);
		if (resultFails + seqFails == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* aluTop.f */
source/aluPkg.sv
source/operandRegister.sv
source/addSubUnit.sv
source/multiplierArray.sv
source/divModUnit.sv
source/resultSelect.sv
source/aluTop.sv
dv/clockGen.sv
dv/aluTb.sv

/* run.sh */
#!/bin/sh
# Builds the ALU testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module aluTb -f aluTop.f

simOutput=$(./obj_dir/ValuTb)
echo "$simOutput"

if echo "$simOutput" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1
